//--- rtl/loopPkg.sv
// shared widths, register map, control struct and bus access struct for the loop filter
package loopPkg;

    localparam int accWidth  = 32;  // integrator, gain outputs, limit, loopFreq
    localparam int expWidth  = 5;   // gain exponent
    localparam int lockWidth = 16;  // lockCount and lock counter
    localparam int addrWidth = 13;
    localparam int dataWidth = 32;  // bus data and readback

    // word addresses, anything else reads as zero
    typedef enum logic [addrWidth-1:0] {
        regCtrl  = 0,
        regGain  = 1,
        regLimit = 2,
        regLock  = 3,
        regAccum = 4   // read only
    } loopRegAddr;

    // controls handed from the register bank to the datapath
    typedef struct packed {
        logic                invertError;  // regCtrl bit 0
        logic                zeroError;    // regCtrl bit 1
        logic                ctrl2;        // regCtrl bit 2
        logic                ctrl4;        // regCtrl bit 4
        logic [expWidth-1:0] leadExp;      // regGain 4..0
        logic [expWidth-1:0] lagExp;       // regGain 12..8
        logic [accWidth-1:0] limit;        // regLimit
    } loopCtrlT;

    // one processor bus access
    typedef struct packed {
        logic                 cs;
        logic [3:0]           byteWr;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
    } busWriteT;

endpackage

//--- rtl/gainShifter.sv
// registered power-of-two gain stage for one sign-extended error sample
module gainShifter #(
    parameter int errorWidth = 12
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clkEn,
    input  logic signed [errorWidth-1:0]        sample,
    input  logic [loopPkg::expWidth-1:0]        exponent,
    output logic signed [loopPkg::accWidth-1:0] scaled
);
    import loopPkg::*;

    localparam int unityExp = errorWidth - 1;  // exponent that passes the sample as is

    logic signed [accWidth-1:0] extended;
    logic signed [accWidth-1:0] shifted;

    assign extended = sample;  // sign extension to accumulator width

    always_comb begin
        if (exponent == '0) begin
            shifted = '0;  // gain off
        end else if (int'(exponent) >= unityExp) begin
            shifted = extended <<< (int'(exponent) - unityExp);
        end else begin
            // fraction bits fall off the bottom
            shifted = extended >>> (unityExp - int'(exponent));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scaled <= '0;
        end else if (clkEn) begin
            scaled <= shifted;
        end
    end

endmodule

//--- rtl/lagIntegrator.sv
// lag path integrator with symmetric signed clamp and saturation flags
module lagIntegrator (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clkEn,
    input  logic                                clearAccum,
    input  logic signed [loopPkg::accWidth-1:0] increment,
    input  logic signed [loopPkg::accWidth-1:0] limit,
    output logic signed [loopPkg::accWidth-1:0] lagAccum,
    output logic                                satPos,
    output logic                                satNeg
);
    import loopPkg::*;

    logic signed [accWidth-1:0] sum;
    logic signed [accWidth-1:0] lowerLimit;

    assign sum        = lagAccum + increment;  // wraps at accWidth
    assign lowerLimit = -limit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (clearAccum) begin
            // processor clear wins over a strobe
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (clkEn) begin
            if (sum >= limit) begin
                lagAccum <= limit;
                satPos   <= 1'b1;
                satNeg   <= 1'b0;
            end else if (sum < lowerLimit) begin
                lagAccum <= lowerLimit;
                satPos   <= 1'b0;
                satNeg   <= 1'b1;
            end else begin
                lagAccum <= sum;
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end
        end
    end

    // only one side can be clamped
    assert property (@(posedge clk) disable iff (reset) !(satPos && satNeg));

endmodule

//--- rtl/lockDetector.sv
// lock detector counting consecutive in-threshold errors
module lockDetector #(
    parameter int errorWidth = 12
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clkEn,
    input  logic signed [errorWidth-1:0]  loopError,
    input  logic [loopPkg::lockWidth-1:0] lockCount,
    input  logic [errorWidth-1:0]         syncThreshold,
    output logic                          locked
);
    import loopPkg::*;

    logic [errorWidth-1:0] magnitude;  // unsigned, so the most negative error still fits
    logic [lockWidth-1:0]  goodCount;
    logic                  inThreshold;

    assign magnitude   = loopError[errorWidth-1] ? -loopError : loopError;
    assign inThreshold = (magnitude <= syncThreshold);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            goodCount <= '0;
        end else if (clkEn) begin
            if (!inThreshold) begin
                goodCount <= '0;                  // streak broken
            end else if (goodCount < lockCount) begin
                goodCount <= goodCount + 1'b1;
            end else begin
                goodCount <= lockCount;           // hold, also after lockCount is lowered
            end
        end
    end

    // lockCount of zero disables lock
    assign locked = (lockCount != '0) && (goodCount == lockCount);

endmodule

//--- rtl/loopFilter.sv
// loop filter datapath: error conditioning, lead and lag gains, integrator, output sum
module loopFilter #(
    parameter int errorWidth = 12
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clkEn,
    input  logic signed [errorWidth-1:0]        error,
    input  loopPkg::loopCtrlT                   ctrl,
    input  logic                                clearAccum,
    output logic signed [errorWidth-1:0]        loopError,
    output logic signed [loopPkg::accWidth-1:0] lagAccum,
    output logic signed [loopPkg::accWidth-1:0] loopFreq,
    output logic                                satPos,
    output logic                                satNeg
);
    import loopPkg::*;

    logic signed [accWidth-1:0] leadError;
    logic signed [accWidth-1:0] lagError;

    // conditioned error, stage 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopError <= '0;
        end else if (clkEn) begin
            if (ctrl.zeroError) begin
                loopError <= '0;      // zero wins over invert
            end else if (ctrl.invertError) begin
                loopError <= -error;
            end else begin
                loopError <= error;
            end
        end
    end

    gainShifter #(
        .errorWidth(errorWidth)
    ) leadGain (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .sample  (loopError),
        .exponent(ctrl.leadExp),
        .scaled  (leadError)
    );

    gainShifter #(
        .errorWidth(errorWidth)
    ) lagGain (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .sample  (loopError),
        .exponent(ctrl.lagExp),
        .scaled  (lagError)
    );

    lagIntegrator lagInt (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .clearAccum(clearAccum),
        .increment (lagError),
        .limit     (ctrl.limit),
        .lagAccum  (lagAccum),
        .satPos    (satPos),
        .satNeg    (satNeg)
    );

    // proportional plus integral, lead lands one strobe before the lag term
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopFreq <= '0;
        end else if (clkEn) begin
            loopFreq <= lagAccum + leadError;
        end
    end

endmodule

//--- rtl/loopRegs.sv
// processor register bank with byte writes, readback mux and clearAccum pulse
module loopRegs #(
    parameter int errorWidth = 12
) (
    input  logic                          clk,
    input  logic                          reset,
    input  loopPkg::busWriteT             bus,
    input  logic [loopPkg::accWidth-1:0]  lagAccum,
    output logic [loopPkg::dataWidth-1:0] dout,
    output loopPkg::loopCtrlT             ctrl,
    output logic                          clearAccum,
    output logic [loopPkg::lockWidth-1:0] lockCount,
    output logic [errorWidth-1:0]         syncThreshold
);
    import loopPkg::*;

    logic [dataWidth-1:0] ctrlWord;  // register images as seen on readback
    logic [dataWidth-1:0] gainWord;
    logic [dataWidth-1:0] lockWord;
    logic [dataWidth-1:0] ctrlNext;
    logic [dataWidth-1:0] gainNext;
    logic [dataWidth-1:0] limitNext;
    logic [dataWidth-1:0] lockNext;
    logic                 wrCtrl;
    logic                 wrGain;
    logic                 wrLimit;
    logic                 wrLock;

    // replace only the bytes with their strobe set
    function automatic logic [dataWidth-1:0] mergeBytes(
        input logic [dataWidth-1:0] oldWord,
        input logic [dataWidth-1:0] newWord,
        input logic [3:0]           byteWr
    );
        logic [dataWidth-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (byteWr[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign wrCtrl  = bus.cs && (bus.addr == regCtrl);
    assign wrGain  = bus.cs && (bus.addr == regGain);
    assign wrLimit = bus.cs && (bus.addr == regLimit);
    assign wrLock  = bus.cs && (bus.addr == regLock);

    always_comb begin
        ctrlWord = '0;
        ctrlWord[0] = ctrl.invertError;
        ctrlWord[1] = ctrl.zeroError;
        ctrlWord[2] = ctrl.ctrl2;
        ctrlWord[4] = ctrl.ctrl4;      // bit 3 is the clear strobe, never stored
        gainWord = '0;
        gainWord[expWidth-1:0] = ctrl.leadExp;
        gainWord[8 +: expWidth] = ctrl.lagExp;
        lockWord = '0;
        lockWord[lockWidth-1:0] = lockCount;
        lockWord[lockWidth +: errorWidth] = syncThreshold;
    end

    assign ctrlNext  = mergeBytes(ctrlWord, bus.data, bus.byteWr);
    assign gainNext  = mergeBytes(gainWord, bus.data, bus.byteWr);
    assign limitNext = mergeBytes(ctrl.limit, bus.data, bus.byteWr);
    assign lockNext  = mergeBytes(lockWord, bus.data, bus.byteWr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl          <= '0;
            lockCount     <= '0;
            syncThreshold <= '0;
            clearAccum    <= 1'b0;
        end else begin
            if (wrCtrl) begin
                ctrl.invertError <= ctrlNext[0];
                ctrl.zeroError   <= ctrlNext[1];
                ctrl.ctrl2       <= ctrlNext[2];
                ctrl.ctrl4       <= ctrlNext[4];
            end
            if (wrGain) begin
                ctrl.leadExp <= gainNext[expWidth-1:0];
                ctrl.lagExp  <= gainNext[8 +: expWidth];
            end
            if (wrLimit) begin
                ctrl.limit <= limitNext;
            end
            if (wrLock) begin
                lockCount     <= lockNext[lockWidth-1:0];
                syncThreshold <= lockNext[lockWidth +: errorWidth];
            end
            // back-to-back clear writes collapse into one pulse
            clearAccum <= wrCtrl && bus.byteWr[0] && bus.data[3] && !clearAccum;
        end
    end

    // readback, combinational while selected
    always_comb begin
        dout = '0;
        if (bus.cs) begin
            case (bus.addr)
                regCtrl:  dout = ctrlWord;
                regGain:  dout = gainWord;
                regLimit: dout = ctrl.limit;
                regLock:  dout = lockWord;
                regAccum: dout = lagAccum;
                default:  dout = '0;
            endcase
        end
    end

    // the integrator sees at most one clear per write
    assert property (@(posedge clk) disable iff (reset) clearAccum |=> !clearAccum);

endmodule

//--- rtl/loopFilterTop.sv
// top level wiring of register bank, loop filter datapath and lock detector
module loopFilterTop #(
    parameter int errorWidth = 12
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clkEn,
    input  loopPkg::busWriteT                   bus,
    input  logic signed [errorWidth-1:0]        error,
    output logic [loopPkg::dataWidth-1:0]       dout,
    output logic signed [loopPkg::accWidth-1:0] loopFreq,
    output logic                                ctrl2,
    output logic                                ctrl4,
    output logic                                satPos,
    output logic                                satNeg,
    output logic                                locked
);
    import loopPkg::*;

    loopCtrlT                   ctrl;
    logic                       clearAccum;
    logic signed [accWidth-1:0] lagAccum;
    logic [lockWidth-1:0]       lockCount;
    logic [errorWidth-1:0]      syncThreshold;
    logic signed [errorWidth-1:0] loopError;  // conditioned error for the lock check

    assign ctrl2 = ctrl.ctrl2;  // spare control bits, passed out as is
    assign ctrl4 = ctrl.ctrl4;

    loopRegs #(
        .errorWidth(errorWidth)
    ) regs (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .lagAccum     (lagAccum),
        .dout         (dout),
        .ctrl         (ctrl),
        .clearAccum   (clearAccum),
        .lockCount    (lockCount),
        .syncThreshold(syncThreshold)
    );

    loopFilter #(
        .errorWidth(errorWidth)
    ) filter (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .error     (error),
        .ctrl      (ctrl),
        .clearAccum(clearAccum),
        .loopError (loopError),
        .lagAccum  (lagAccum),
        .loopFreq  (loopFreq),
        .satPos    (satPos),
        .satNeg    (satNeg)
    );

    lockDetector #(
        .errorWidth(errorWidth)
    ) lockDet (
        .clk          (clk),
        .reset        (reset),
        .clkEn        (clkEn),
        .loopError    (loopError),
        .lockCount    (lockCount),
        .syncThreshold(syncThreshold),
        .locked       (locked)
    );

endmodule

//--- tb/loopFilterTb.sv
// table-driven testbench for loopFilterTop with a strobe-level reference model
module loopFilterTb;
    import loopPkg::*;

    localparam int         errorWidth = 12;
    localparam int         stepCount  = 38;
    localparam logic [1:0] kindWrite  = 2'd0;
    localparam logic [1:0] kindRead   = 2'd1;
    localparam logic [1:0] kindRun    = 2'd2;

    // data holds write data, expected readback or the error value of a run
    typedef struct packed {
        logic [1:0]           kind;
        logic [addrWidth-1:0] addr;
        logic [31:0]          data;
        logic [3:0]           strb;   // byte strobes, or clkEn pattern of a run
        logic [7:0]           count;
        logic                 rnd;    // random error samples
    } stepT;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         clkEn;
    busWriteT                     bus;
    logic signed [errorWidth-1:0] error;
    logic [31:0]                  dout;
    logic signed [31:0]           loopFreq;
    logic                         ctrl2;
    logic                         ctrl4;
    logic                         satPos;
    logic                         satNeg;
    logic                         locked;

    stepT   steps [stepCount];
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     cycleLimit = 0;
    integer seed = 32'h7448;

    // reference model state
    logic [31:0]                  mCtrl = '0;
    logic [31:0]                  mGain = '0;
    logic [31:0]                  mLimit = '0;
    logic [31:0]                  mLock = '0;
    logic signed [errorWidth-1:0] mErr = '0;
    logic signed [31:0]           mLead = '0;
    logic signed [31:0]           mLag = '0;
    logic signed [31:0]           mAcc = '0;
    logic signed [31:0]           mFreq = '0;
    logic                         mSatPos = 1'b0;
    logic                         mSatNeg = 1'b0;
    logic                         mLocked = 1'b0;
    logic                         clearPend = 1'b0;
    logic                         lockSeen = 1'b0;
    int                           mGood = 0;
    logic                         pendEn = 1'b0;       // inputs waiting for the next edge
    logic signed [errorWidth-1:0] pendErr = '0;
    busWriteT                     pendBus = '0;

    always #2 clk = ~clk;

    loopFilterTop #(.errorWidth(errorWidth)) loopFilterTop_inst (.*);

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the step table did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    function automatic stepT writeStep(input logic [addrWidth-1:0] addr,
                                       input logic [31:0] data, input logic [3:0] strb);
        return '{kind: kindWrite, addr: addr, data: data, strb: strb, count: 8'd1, rnd: 1'b0};
    endfunction

    function automatic stepT readStep(input logic [addrWidth-1:0] addr,
                                      input logic [31:0] expected);
        return '{kind: kindRead, addr: addr, data: expected, strb: 4'h0, count: 8'd1,
                 rnd: 1'b0};
    endfunction

    function automatic stepT runStep(input int count, input int err, input logic [3:0] pattern,
                                     input logic rnd);
        return '{kind: kindRun, addr: '0, data: err, strb: pattern, count: 8'(count), rnd: rnd};
    endfunction

    // power-of-two gain, exponent errorWidth-1 is unity
    function automatic logic signed [31:0] scaleByGain(input logic signed [errorWidth-1:0] e,
                                                       input logic [4:0] exponent);
        logic signed [31:0] wide;
        int                 shift;
        wide  = 32'(e);
        shift = int'(exponent) - (errorWidth - 1);
        if (exponent == 5'd0) return '0;
        if (shift >= 0) return wide <<< shift;
        return wide >>> (-shift);
    endfunction

    function automatic logic [31:0] mergeByteWrite(input logic [31:0] old,
                                                   input logic [31:0] data,
                                                   input logic [3:0] strb,
                                                   input logic [31:0] keep);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) old[8*i +: 8] = data[8*i +: 8];
        end
        return old & keep;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error: %s is %h, expected %h at time %0t", name, actual, expected, $time);
        end
    endtask

    // one clock edge of the filter recurrence, old values feed every stage
    task automatic advanceModel(input logic en, input logic signed [errorWidth-1:0] err,
                                input busWriteT b);
        logic signed [31:0] sum;
        logic signed [31:0] limit;
        int                 magnitude;
        int                 lockCnt;
        limit   = mLimit;
        lockCnt = int'(mLock[15:0]);
        sum     = mAcc + mLag;
        if (en) mFreq = mAcc + mLead;
        if (clearPend) begin
            mAcc    = '0;
            mSatPos = 1'b0;
            mSatNeg = 1'b0;
        end else if (en) begin
            mSatPos = (sum >= limit);
            mSatNeg = !mSatPos && (sum < -limit);
            mAcc    = mSatPos ? limit : (mSatNeg ? -limit : sum);
        end
        if (en) begin
            mLead     = scaleByGain(mErr, mGain[4:0]);
            mLag      = scaleByGain(mErr, mGain[12:8]);
            magnitude = int'(mErr);
            if (magnitude < 0) magnitude = -magnitude;
            if (magnitude > int'(mLock[27:16])) mGood = 0;
            else if (mGood < lockCnt) mGood++;
            else mGood = lockCnt;
            if (mCtrl[1]) mErr = '0;
            else if (mCtrl[0]) mErr = -err;
            else mErr = err;
        end
        clearPend = b.cs && (b.addr == regCtrl) && b.byteWr[0] && b.data[3];
        if (b.cs) begin
            case (b.addr)
                regCtrl:  mCtrl  = mergeByteWrite(mCtrl, b.data, b.byteWr, 32'h0000_0017);
                regGain:  mGain  = mergeByteWrite(mGain, b.data, b.byteWr, 32'h0000_1f1f);
                regLimit: mLimit = mergeByteWrite(mLimit, b.data, b.byteWr, 32'hffff_ffff);
                regLock:  mLock  = mergeByteWrite(mLock, b.data, b.byteWr, 32'h0fff_ffff);
                default: ;
            endcase
        end
        mLocked = (mLock[15:0] != 16'd0) && (mGood == int'(mLock[15:0]));
    endtask

    task automatic runCycle(input logic en, input logic signed [errorWidth-1:0] err,
                            input busWriteT b);
        @(posedge clk);
        clkEn <= en;
        error <= err;
        bus   <= b;
        @(negedge clk);
        advanceModel(pendEn, pendErr, pendBus);  // the edge just passed took these
        pendEn  = en;
        pendErr = err;
        pendBus = b;
        checkValue("loopFreq", loopFreq, mFreq);
        checkValue("satPos", 32'(satPos), 32'(mSatPos));
        checkValue("satNeg", 32'(satNeg), 32'(mSatNeg));
        checkValue("locked", 32'(locked), 32'(mLocked));
        checkValue("ctrl2", 32'(ctrl2), 32'(mCtrl[2]));
        checkValue("ctrl4", 32'(ctrl4), 32'(mCtrl[4]));
        if (locked) lockSeen = 1'b1;  // the DUT itself reached lock
    endtask

    initial begin
        stepT                         st;
        busWriteT                     access;
        logic signed [errorWidth-1:0] sample;
        logic [31:0]                  randomWord;
        int                           totalCycles;
        reset = 1'b1;
        clkEn = 1'b0;
        error = '0;
        bus   = '0;
        // register access
        steps[0]  = writeStep(regGain, 32'h0000_0b0b, 4'hf);
        steps[1]  = writeStep(regGain, 32'hffff_1403, 4'b0001);
        steps[2]  = readStep(regGain, 32'h0000_0b03);
        steps[3]  = writeStep(regLimit, 32'h1234_5678, 4'hf);
        steps[4]  = writeStep(regLimit, 32'haabb_ccdd, 4'b1010);
        steps[5]  = readStep(regLimit, 32'haa34_cc78);
        steps[6]  = writeStep(regLock, 32'hffff_ffff, 4'hf);
        steps[7]  = readStep(regLock, 32'h0fff_ffff);
        steps[8]  = readStep(13'h0007, 32'h0);               // unmapped
        steps[9]  = writeStep(regCtrl, 32'h0000_0014, 4'hf);  // ctrl2 and ctrl4
        steps[10] = writeStep(regCtrl, 32'h0, 4'hf);
        // unity gains, then strobes with gaps
        steps[11] = writeStep(regGain, 32'h0000_0b0b, 4'hf);
        steps[12] = writeStep(regLimit, 32'h7fff_ffff, 4'hf);
        steps[13] = runStep(6, 100, 4'b1111, 1'b0);
        steps[14] = runStep(8, -37, 4'b0101, 1'b0);
        // invert, then zero
        steps[15] = writeStep(regCtrl, 32'h0000_0001, 4'hf);
        steps[16] = runStep(6, 50, 4'b1011, 1'b0);
        steps[17] = writeStep(regCtrl, 32'h0000_0002, 4'hf);
        steps[18] = runStep(6, 300, 4'b1111, 1'b0);
        // gain range with exponents 3, 20 and 0
        steps[19] = writeStep(regCtrl, 32'h0000_0008, 4'hf);
        steps[20] = writeStep(regGain, 32'h0000_1403, 4'hf);
        steps[21] = runStep(12, 0, 4'b1111, 1'b1);
        steps[22] = writeStep(regGain, 32'h0000_0300, 4'hf);
        steps[23] = runStep(12, 0, 4'b0111, 1'b1);
        // saturation both ways, then clear
        steps[24] = writeStep(regCtrl, 32'h0000_0008, 4'hf);
        steps[25] = writeStep(regGain, 32'h0000_0b0b, 4'hf);
        steps[26] = writeStep(regLimit, 32'h0000_0100, 4'hf);
        steps[27] = runStep(5, 2047, 4'b1111, 1'b0);
        steps[28] = readStep(regAccum, 32'h0000_0100);
        steps[29] = runStep(6, -2048, 4'b1111, 1'b0);
        steps[30] = readStep(regAccum, 32'hffff_ff00);
        steps[31] = writeStep(regCtrl, 32'h0000_0008, 4'hf);
        steps[32] = runStep(2, 0, 4'b0000, 1'b0);
        steps[33] = readStep(regAccum, 32'h0);
        // lock after 4 strobes within 20, one large error breaks it
        steps[34] = writeStep(regLock, 32'h0014_0004, 4'hf);
        steps[35] = runStep(8, 10, 4'b1111, 1'b0);
        steps[36] = runStep(1, 200, 4'b1111, 1'b0);
        steps[37] = runStep(6, -15, 4'b1111, 1'b0);
        totalCycles = 5 + 3;
        foreach (steps[s]) totalCycles += (steps[s].kind == kindRun) ? int'(steps[s].count) : 1;
        cycleLimit = totalCycles + 20;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[s]) begin
            st = steps[s];
            case (st.kind)
                kindWrite: begin
                    access = '{cs: 1'b1, byteWr: st.strb, addr: st.addr, data: st.data};
                    runCycle(1'b0, '0, access);
                end
                kindRead: begin
                    access = '{cs: 1'b1, byteWr: 4'h0, addr: st.addr, data: 32'h0};
                    runCycle(1'b0, '0, access);
                    checkValue("dout", dout, st.data);
                end
                default: begin
                    for (int n = 0; n < int'(st.count); n++) begin
                        sample = st.data[errorWidth-1:0];
                        if (st.rnd) begin
                            randomWord = $random(seed);
                            sample     = randomWord[errorWidth-1:0];
                        end
                        runCycle(st.strb[n % 4], sample, '0);
                    end
                end
            endcase
        end
        repeat (3) runCycle(1'b0, '0, '0);
        if (!lockSeen) begin
            errorCount++;
            $display("the lock sequence never brought the detector into lock");
        end
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/loopPkg.sv
rtl/gainShifter.sv
rtl/lagIntegrator.sv
rtl/lockDetector.sv
rtl/loopFilter.sv
rtl/loopRegs.sv
rtl/loopFilterTop.sv
tb/loopFilterTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module loopFilterTb \
		-f sim.f -Mdir obj_dir -o loopFilterSim

run: compile
	./obj_dir/loopFilterSim | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
